// File: pool_pkg.sv
// package with sample, uart, window and credit constants, command and state enums, header byte
`default_nettype none

package pool_pkg;

    // adc sample and the two halves sent in a frame
    localparam int SAMPLE_W = 10;
    localparam int HALF_W = 5;

    // uart bit period in clk cycles, 8N1 fixed rate
    localparam int CLKS_PER_BIT = 16;

    // peak is dropped once per window
    localparam int WINDOW_CYCLES = 65536;

    // words the transmitter can hold ahead of its shifter
    localparam int TX_CREDITS = 1;

    // frame layout: header byte, then data bytes tagged with a 3-bit prefix
    localparam logic [7:0] HEADER_BYTE = 8'h41;
    localparam logic [2:0] DATA_PREFIX = 3'b100;

    // host command bytes, anything else is ignored
    typedef enum logic [7:0] {
        CMD_CLEAR    = 8'h52,
        CMD_SNAPSHOT = 8'h53
    } cmd_e;

    // frame sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_HEADER = 2'd1,
        SEQ_LOW    = 2'd2,
        SEQ_HIGH   = 2'd3
    } seq_state_e;

endpackage

`default_nettype wire

// File: adc_peak_logger.sv
// serial adc capture, window timer and peak-hold register with clear
`timescale 1ns/1ps
`default_nettype none

module adc_peak_logger (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          adc_data,
    input  logic                          adc_shift,
    input  logic                          adc_done,
    input  logic                          peak_clear,
    output logic [pool_pkg::SAMPLE_W-1:0] peak
);

    localparam int SHIFT_W = $clog2(pool_pkg::SAMPLE_W + 1);
    localparam int WIN_W = $clog2(pool_pkg::WINDOW_CYCLES);

    logic [pool_pkg::SAMPLE_W-1:0] shift_reg;
    logic [SHIFT_W-1:0]            shift_cnt;
    logic [WIN_W-1:0]              win_cnt;
    logic                          window_end;

    // adc word comes in msb first
    always_ff @(posedge clk) begin
        if (adc_shift) begin
            shift_reg <= {shift_reg[pool_pkg::SAMPLE_W-2:0], adc_data};
        end
    end

    // bits taken since the last complete sample
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_cnt <= '0;
        end else if (adc_done) begin
            shift_cnt <= '0;
        end else if (adc_shift && shift_cnt != '1) begin
            // saturates so a stray strobe can't wrap the count back to a legal value
            shift_cnt <= shift_cnt + 1'b1;
        end
    end

    // free-running window timer
    assign window_end = (win_cnt == WIN_W'(pool_pkg::WINDOW_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            win_cnt <= '0;
        end else if (window_end) begin
            win_cnt <= '0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    // peak hold
    // a clear in the same cycle as adc_done wins and drops that sample
    always_ff @(posedge clk) begin
        if (reset) begin
            peak <= '0;
        end else if (peak_clear || window_end) begin
            peak <= '0;
        end else if (adc_done && (shift_reg > peak)) begin
            peak <= shift_reg;
        end
    end

    // the adc must deliver exactly one full word between done strobes
    a_done_after_full_word: assert property (
        @(posedge clk) disable iff (reset)
        adc_done |-> (shift_cnt == SHIFT_W'(pool_pkg::SAMPLE_W))
    ) else $error("adc_done after %0d shifts", shift_cnt);

endmodule

`default_nettype wire

// File: frame_sequencer.sv
// command decode, peak snapshot, three-word frame FSM and transmit credit counter
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [7:0]                    rx_byte,
    input  logic                          rx_valid,
    input  logic [pool_pkg::SAMPLE_W-1:0] peak,
    output logic                          peak_clear,
    output logic [7:0]                    tx_word,
    output logic                          tx_word_valid,
    input  logic                          tx_credit
);

    localparam int CRED_W = $clog2(pool_pkg::TX_CREDITS + 1);
    localparam int H = pool_pkg::HALF_W;
    localparam int S = pool_pkg::SAMPLE_W;

    pool_pkg::seq_state_e state;
    pool_pkg::cmd_e       cmd;
    logic [CRED_W-1:0]    credit_cnt;
    logic [S-1:0]         frozen;
    logic                 snap_req;
    logic                 push;

    // host byte seen as a command, unknown values fall to default
    assign cmd = pool_pkg::cmd_e'(rx_byte);
    assign snap_req = (state == pool_pkg::SEQ_IDLE) && rx_valid
                      && (cmd == pool_pkg::CMD_SNAPSHOT);

    // a word goes out whenever a frame is active and a credit is held
    assign push = (state != pool_pkg::SEQ_IDLE) && (credit_cnt != '0);
    assign tx_word_valid = push;

    // frame words come from the frozen copy so new samples can't leak in
    always_comb begin
        case (state)
            pool_pkg::SEQ_HEADER: tx_word = pool_pkg::HEADER_BYTE;
            pool_pkg::SEQ_LOW:    tx_word = {pool_pkg::DATA_PREFIX, frozen[H-1:0]};
            pool_pkg::SEQ_HIGH:   tx_word = {pool_pkg::DATA_PREFIX, frozen[S-1:H]};
            default:              tx_word = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (snap_req) begin
            frozen <= peak;
        end
    end

    // frame FSM, commands are only decoded while idle
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= pool_pkg::SEQ_IDLE;
            peak_clear <= 1'b0;
        end else begin
            peak_clear <= 1'b0;
            case (state)
                pool_pkg::SEQ_IDLE: begin
                    if (rx_valid) begin
                        case (cmd)
                            pool_pkg::CMD_SNAPSHOT: state <= pool_pkg::SEQ_HEADER;
                            pool_pkg::CMD_CLEAR:    peak_clear <= 1'b1;
                            default:                ;
                        endcase
                    end
                end
                // no credit means the state just waits
                pool_pkg::SEQ_HEADER: if (push) state <= pool_pkg::SEQ_LOW;
                pool_pkg::SEQ_LOW:    if (push) state <= pool_pkg::SEQ_HIGH;
                pool_pkg::SEQ_HIGH:   if (push) state <= pool_pkg::SEQ_IDLE;
                default:              state <= pool_pkg::SEQ_IDLE;
            endcase
        end
    end

    // spend one per push, get one back per tx_credit pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CRED_W'(pool_pkg::TX_CREDITS);
        end else begin
            case ({push, tx_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // a returned credit must never push the count past TX_CREDITS
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset)
        (tx_credit && !push) |-> (credit_cnt < CRED_W'(pool_pkg::TX_CREDITS))
    ) else $error("credit returned with count already full");

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8N1 uart transmitter with one-word holding register and credit return
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_word,
    input  logic       tx_word_valid,
    output logic       tx_credit,
    output logic       tx
);

    localparam int CNT_W = $clog2(pool_pkg::CLKS_PER_BIT);

    logic [7:0]       hold_reg;
    logic             hold_full;
    logic [9:0]       shift_reg;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic             busy;
    logic             load;

    // held word moves into an idle shifter, which frees the slot
    assign load = hold_full && !busy;
    assign tx_credit = load;

    // holding register
    // a push in the load cycle simply refills it
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_full <= 1'b0;
        end else if (tx_word_valid) begin
            hold_full <= 1'b1;
        end else if (load) begin
            hold_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_word_valid) begin
            hold_reg <= tx_word;
        end
    end

    // shifter, line is bit 0, ones fill in behind so idle stays high
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_reg <= '1;
            busy      <= 1'b0;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
        end else if (load) begin
            // stop, data lsb first, start
            shift_reg <= {1'b1, hold_reg, 1'b0};
            busy      <= 1'b1;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
        end else if (busy) begin
            if (clk_cnt == CNT_W'(pool_pkg::CLKS_PER_BIT - 1)) begin
                clk_cnt   <= '0;
                shift_reg <= {1'b1, shift_reg[9:1]};
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    assign tx = shift_reg[0];

    // sender must hold a credit, so a push never lands on a full slot
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        tx_word_valid |-> !hold_full
    ) else $error("tx_word_valid while holding register full");

endmodule

`default_nettype wire

// File: uart_rx.sv
// 8N1 uart receiver with two-flop synchroniser, mid-bit sampling and byte strobe
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int CNT_W = $clog2(pool_pkg::CLKS_PER_BIT);
    localparam int MID = pool_pkg::CLKS_PER_BIT / 2 - 1;

    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [7:0]       data_reg;
    logic             busy;
    logic             mid_bit;

    // rx is asynchronous to clk
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign mid_bit = busy && (clk_cnt == CNT_W'(MID));

    // bit 0 is start, 1 to 8 data, 9 stop
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                // falling edge starts a frame
                if (!rx_sync) begin
                    busy    <= 1'b1;
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else begin
                if (clk_cnt == CNT_W'(pool_pkg::CLKS_PER_BIT - 1)) begin
                    clk_cnt <= '0;
                    bit_cnt <= bit_cnt + 1'b1;
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
                if (mid_bit && bit_cnt == 4'd0 && rx_sync) begin
                    // glitch, start bit gone by mid-period
                    busy <= 1'b0;
                end
                if (mid_bit && bit_cnt == 4'd9) begin
                    // done at mid-stop so the next start edge is caught early
                    busy     <= 1'b0;
                    // low stop bit means framing error, byte dropped
                    rx_valid <= rx_sync;
                end
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (mid_bit && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            data_reg <= {rx_sync, data_reg[7:1]};
        end
    end

    // byte stays put until the next good frame
    always_ff @(posedge clk) begin
        if (mid_bit && bit_cnt == 4'd9 && rx_sync) begin
            rx_byte <= data_reg;
        end
    end

endmodule

`default_nettype wire

// File: pool_logger_top.sv
// top level joining the peak logger, frame sequencer and both uart halves
`timescale 1ns/1ps
`default_nettype none

module pool_logger_top (
    input  logic clk,
    input  logic reset,
    input  logic adc_data,
    input  logic adc_shift,
    input  logic adc_done,
    input  logic rx,
    output logic tx
);

    // logger to sequencer
    logic [pool_pkg::SAMPLE_W-1:0] peak;
    logic                          peak_clear;

    // host receive path
    logic [7:0] rx_byte;
    logic       rx_valid;

    // credit link to the transmitter
    logic [7:0] tx_word;
    logic       tx_word_valid;
    logic       tx_credit;

    adc_peak_logger u_logger (
        .clk        (clk),
        .reset      (reset),
        .adc_data   (adc_data),
        .adc_shift  (adc_shift),
        .adc_done   (adc_done),
        .peak_clear (peak_clear),
        .peak       (peak)
    );

    frame_sequencer u_seq (
        .clk           (clk),
        .reset         (reset),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .peak          (peak),
        .peak_clear    (peak_clear),
        .tx_word       (tx_word),
        .tx_word_valid (tx_word_valid),
        .tx_credit     (tx_credit)
    );

    uart_rx u_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    uart_tx u_tx (
        .clk           (clk),
        .reset         (reset),
        .tx_word       (tx_word),
        .tx_word_valid (tx_word_valid),
        .tx_credit     (tx_credit),
        .tx            (tx)
    );

endmodule

`default_nettype wire

// File: tb_pool_logger.sv
// testbench for pool_logger_top with a step table, lfsr samples, uart host model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_pool_logger;

    localparam int C = pool_pkg::CLKS_PER_BIT;
    localparam int S = pool_pkg::SAMPLE_W;
    localparam int H = pool_pkg::HALF_W;

    typedef enum int {
        ACT_SAMPLES,
        ACT_HOST_BYTE,
        ACT_FRAME,
        ACT_SILENCE,
        ACT_IDLE
    } act_e;

    logic clk;
    logic reset;
    logic adc_data;
    logic adc_shift;
    logic adc_done;
    logic rx;
    logic tx;

    // step table, one entry per row in each queue
    string       step_name[$];
    act_e        step_act[$];
    int          step_count[$];
    logic [31:0] step_value[$];

    // lfsr state and the reference running maximum
    logic [15:0] lfsr;
    int          model_max;

    pool_logger_top uut (
        .clk       (clk),
        .reset     (reset),
        .adc_data  (adc_data),
        .adc_shift (adc_shift),
        .adc_done  (adc_done),
        .rx        (rx),
        .tx        (tx)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // inputs change and outputs are read 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "timeout");
    endtask

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per sample bit
    task automatic next_sample(output logic [S-1:0] value);
        value = '0;
        for (int b = 0; b < S; b++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[S-2:0], lfsr[0]};
        end
    endtask

    // msb first on adc_shift strobes, then one adc_done
    task automatic drive_samples(input int count, input logic [S-1:0] mask,
                                 input logic [S-1:0] force_bits);
        logic [S-1:0] raw;
        logic [S-1:0] value;
        for (int n = 0; n < count; n++) begin
            next_sample(raw);
            value = (raw & mask) | force_bits;
            for (int b = S - 1; b >= 0; b--) begin
                adc_shift = 1'b1;
                adc_data  = value[b];
                tick();
            end
            adc_shift = 1'b0;
            adc_data  = 1'b0;
            adc_done  = 1'b1;
            tick();
            adc_done = 1'b0;
            if (int'(value) > model_max) begin
                model_max = int'(value);
            end
        end
    endtask

    // host side 8N1, returns half way through the stop bit, line then idles high
    task automatic send_host_byte(input logic [7:0] data);
        rx = 1'b0;
        repeat (C) tick();
        for (int b = 0; b < 8; b++) begin
            rx = data[b];
            repeat (C) tick();
        end
        rx = 1'b1;
        repeat (C / 2) tick();
        if (data == pool_pkg::CMD_CLEAR) begin
            model_max = 0;
        end
    endtask

    // waits for the start bit, then samples each bit at mid-period
    task automatic receive_byte(input string name, input int timeout, output logic [7:0] data);
        int waited;
        waited = 0;
        data = '0;
        while (tx !== 1'b0) begin
            if (waited >= timeout) begin
                fail_timeout($sformatf("step %s: no start bit on tx after %0d cycles",
                                       name, timeout));
            end else begin
                tick();
                waited++;
            end
        end
        repeat (C / 2) tick();
        check_value({name, " start bit"}, 0, int'(tx));
        for (int b = 0; b < 8; b++) begin
            repeat (C) tick();
            data[b] = tx;
        end
        repeat (C) tick();
        check_value({name, " stop bit"}, 1, int'(tx));
    endtask

    // header, then prefix 100 over low and high halves of the expected peak
    task automatic expect_frame(input string name, input logic [7:0] header, input int extra);
        logic [7:0] got;
        int         snap_value;
        int         exp_low;
        int         exp_high;
        snap_value = model_max;
        exp_low    = 32'h80 | (snap_value % (1 << H));
        exp_high   = 32'h80 | ((snap_value >> H) % (1 << H));
        fork
            begin
                receive_byte({name, " header"}, 8 * C, got);
                check_value({name, " header"}, int'(header), int'(got));
                receive_byte({name, " low"}, 2 * C, got);
                check_value({name, " low"}, exp_low, int'(got));
                receive_byte({name, " high"}, 2 * C, got);
                check_value({name, " high"}, exp_high, int'(got));
            end
            begin
                // large samples arrive after the snapshot latch, mid frame
                if (extra > 0) begin
                    repeat (C) tick();
                    drive_samples(extra, '1, S'(1) << (S - 1));
                end
            end
        join
    endtask

    // tx must stay idle high for the whole span
    task automatic expect_silence(input string name, input int count);
        for (int n = 0; n < count; n++) begin
            tick();
            check_value(name, 1, int'(tx));
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) tick();
        if (count >= pool_pkg::WINDOW_CYCLES) begin
            model_max = 0;
        end
    endtask

    task automatic add_step(input string name, input act_e act, input int count,
                            input logic [31:0] value);
        step_name.push_back(name);
        step_act.push_back(act);
        step_count.push_back(count);
        step_value.push_back(value);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        adc_data  = 1'b0;
        adc_shift = 1'b0;
        adc_done  = 1'b0;
        rx        = 1'b1;
        lfsr      = 16'd6;
        model_max = 0;

        // name, action, count, value (sample mask, host byte or frame header)
        add_step("reset_quiet",   ACT_SILENCE,   400, 0);
        add_step("samples_a",     ACT_SAMPLES,   8,   32'h3ff);
        add_step("snap_a",        ACT_HOST_BYTE, 1,   pool_pkg::CMD_SNAPSHOT);
        add_step("frame_a",       ACT_FRAME,     0,   pool_pkg::HEADER_BYTE);
        add_step("clear_a",       ACT_HOST_BYTE, 1,   pool_pkg::CMD_CLEAR);
        add_step("clear_gap_a",   ACT_IDLE,      32,  0);
        add_step("samples_small", ACT_SAMPLES,   6,   32'h0ff);
        add_step("snap_b",        ACT_HOST_BYTE, 1,   pool_pkg::CMD_SNAPSHOT);
        add_step("frame_b",       ACT_FRAME,     0,   pool_pkg::HEADER_BYTE);
        add_step("window_idle",   ACT_IDLE,      pool_pkg::WINDOW_CYCLES + 64, 0);
        add_step("snap_c",        ACT_HOST_BYTE, 1,   pool_pkg::CMD_SNAPSHOT);
        add_step("frame_c",       ACT_FRAME,     0,   pool_pkg::HEADER_BYTE);
        add_step("samples_c",     ACT_SAMPLES,   5,   32'h3ff);
        add_step("unknown_cmd",   ACT_HOST_BYTE, 1,   32'h7a);
        add_step("unknown_quiet", ACT_SILENCE,   20 * C, 0);
        add_step("snap_d",        ACT_HOST_BYTE, 1,   pool_pkg::CMD_SNAPSHOT);
        add_step("frame_d",       ACT_FRAME,     0,   pool_pkg::HEADER_BYTE);
        add_step("clear_e",       ACT_HOST_BYTE, 1,   pool_pkg::CMD_CLEAR);
        add_step("clear_gap_e",   ACT_IDLE,      32,  0);
        add_step("samples_e",     ACT_SAMPLES,   4,   32'h0ff);
        add_step("snap_e",        ACT_HOST_BYTE, 1,   pool_pkg::CMD_SNAPSHOT);
        // frozen frame while three larger samples come in
        add_step("frame_e",       ACT_FRAME,     3,   pool_pkg::HEADER_BYTE);
        add_step("snap_f",        ACT_HOST_BYTE, 1,   pool_pkg::CMD_SNAPSHOT);
        add_step("frame_f",       ACT_FRAME,     0,   pool_pkg::HEADER_BYTE);

        repeat (10) tick();
        reset = 1'b0;

        for (int i = 0; i < step_name.size(); i++) begin
            case (step_act[i])
                ACT_SAMPLES:   drive_samples(step_count[i], step_value[i][S-1:0], '0);
                ACT_HOST_BYTE: send_host_byte(step_value[i][7:0]);
                ACT_FRAME:     expect_frame(step_name[i], step_value[i][7:0], step_count[i]);
                ACT_SILENCE:   expect_silence(step_name[i], step_count[i]);
                default:       idle_cycles(step_count[i]);
            endcase
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
pool_pkg.sv
adc_peak_logger.sv
frame_sequencer.sv
uart_tx.sv
uart_rx.sv
pool_logger_top.sv
tb_pool_logger.sv

// File: Makefile
# Verilator build and run for the pool logger testbench

SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= tb_pool_logger
FILELIST ?= tb.f
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
